// ==== verilog/des_pkg.sv ====
package des_pkg;

    // bit 1 is the msb, as in the standard tables.
    typedef logic [1:64] block_t;
    typedef logic [1:32] half_t;
    typedef logic [1:48] subkey_t;
    typedef logic [1:56] cd_t;
    typedef logic [5:0]  sbox_in_t;
    typedef logic [3:0]  sbox_out_t;

    localparam int NUM_ROUNDS = 16;

    // left rotation of C and D before each round.
    localparam int SHIFT_SCHEDULE [NUM_ROUNDS] = '{
        1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
    };

    // index is {row, column}, row from the outer bits, column from the inner four.
    localparam sbox_out_t SBOX [8][64] = '{
        '{
            14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
             0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
             4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
            15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13
        },
        '{
            15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
             3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
             0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
            13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9
        },
        '{
            10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
            13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
            13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
             1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12
        },
        '{
             7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
            13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
            10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
             3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14
        },
        '{
             2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
            14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
             4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
            11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3
        },
        '{
            12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
            10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
             9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
             4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13
        },
        '{
             4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
            13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
             1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
             6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12
        },
        '{
            13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
             1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
             7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
             2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11
        }
    };

endpackage

// ==== verilog/des_round.sv ====
module des_round
    import des_pkg::*;
(
    input  block_t  state_in,
    input  subkey_t subkey,
    output block_t  state_out
);

    localparam int E_TAB [1:48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int P_TAB [1:32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    half_t   l_half;
    half_t   r_half;
    subkey_t expanded;
    subkey_t mixed;
    half_t   s_out;
    half_t   f_out;

    assign l_half = state_in[1:32];
    assign r_half = state_in[33:64];

    always_comb begin
        for (int i = 1; i <= 48; i++) begin
            expanded[i] = r_half[E_TAB[i]];
        end
    end

    assign mixed = expanded ^ subkey;

    always_comb begin
        sbox_in_t s_in;
        for (int b = 0; b < 8; b++) begin
            s_in = mixed[6*b+1 +: 6];
            s_out[4*b+1 +: 4] = SBOX[b][{s_in[5], s_in[0], s_in[4:1]}]; // outer bits pick the row.
        end
    end

    always_comb begin
        for (int i = 1; i <= 32; i++) begin
            f_out[i] = s_out[P_TAB[i]];
        end
    end

    assign state_out = {r_half, l_half ^ f_out};

endmodule

// ==== verilog/des_round_chain.sv ====
module des_round_chain
    import des_pkg::*;
#(
    parameter int FIRST_ROUND = 0,
    parameter int ROUNDS      = 8
) (
    input  logic    ck,
    input  logic    rst_n,
    input  logic    in_valid,
    input  block_t  in_block,
    input  subkey_t subkeys [NUM_ROUNDS],
    output logic    out_valid,
    output block_t  out_block
);

    block_t stage [ROUNDS+1];

    assign stage[0] = in_block;

    for (genvar g = 0; g < ROUNDS; g++) begin : g_round
        des_round u_round (
            .state_in  (stage[g]),
            .subkey    (subkeys[FIRST_ROUND+g]),
            .state_out (stage[g+1])
        );
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge ck) begin
        if (in_valid) begin
            out_block <= stage[ROUNDS]; // holds its value on idle cycles.
        end
    end

    a_valid_known: assert property (
        @(posedge ck) disable iff (!rst_n) !$isunknown(out_valid)
    );

endmodule

// ==== verilog/des_key_schedule.sv ====
module des_key_schedule
    import des_pkg::*;
(
    input  logic    ck,
    input  logic    rst_n,
    input  logic    key_load,
    input  block_t  key,
    input  logic    decrypt,
    input  logic    busy,
    output subkey_t subkeys [NUM_ROUNDS]
);

    localparam int PC1_TAB [1:56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    localparam int PC2_TAB [1:48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    cd_t     cd_init;
    subkey_t next_keys [NUM_ROUNDS];

    always_comb begin
        for (int i = 1; i <= 56; i++) begin
            cd_init[i] = key[PC1_TAB[i]]; // parity bits drop out here.
        end
    end

    // all sixteen rounds of the schedule unrolled in one pass.
    always_comb begin
        logic [1:28] c;
        logic [1:28] d;
        cd_t         cd;
        c = cd_init[1:28];
        d = cd_init[29:56];
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            if (SHIFT_SCHEDULE[r] == 1) begin
                c = {c[2:28], c[1]};
                d = {d[2:28], d[1]};
            end else begin
                c = {c[3:28], c[1:2]};
                d = {d[3:28], d[1:2]};
            end
            cd = {c, d};
            for (int i = 1; i <= 48; i++) begin
                next_keys[r][i] = cd[PC2_TAB[i]];
            end
        end
    end

    always_ff @(posedge ck) begin
        if (key_load) begin
            for (int r = 0; r < NUM_ROUNDS; r++) begin
                // decryption walks the schedule backwards.
                subkeys[r] <= decrypt ? next_keys[NUM_ROUNDS-1-r] : next_keys[r];
            end
        end
    end

    // blocks in flight would mix old and new subkeys.
    a_key_idle: assert property (
        @(posedge ck) disable iff (!rst_n) key_load |-> !busy
    );

endmodule

// ==== verilog/des_core.sv ====
module des_core
    import des_pkg::*;
(
    input  logic   ck,
    input  logic   rst_n,
    input  logic   key_load,
    input  block_t key,
    input  logic   decrypt,
    input  logic   in_valid,
    input  block_t in_block,
    output logic   out_valid,
    output block_t out_block
);

    localparam int HALF_ROUNDS = NUM_ROUNDS / 2;

    localparam int IP_TAB [1:64] = '{
        58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
    };

    localparam int FP_TAB [1:64] = '{
        40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
    };

    subkey_t subkeys [NUM_ROUNDS];
    block_t  ip_next;
    block_t  stage0_block;
    block_t  stage1_block;
    block_t  stage2_block;
    block_t  preout;
    block_t  fp_next;
    logic    stage0_valid;
    logic    stage1_valid;
    logic    stage2_valid;
    logic    busy;

    assign busy = stage0_valid | stage1_valid | stage2_valid | out_valid;

    des_key_schedule u_key_schedule (
        .ck       (ck),
        .rst_n    (rst_n),
        .key_load (key_load),
        .key      (key),
        .decrypt  (decrypt),
        .busy     (busy),
        .subkeys  (subkeys)
    );

    always_comb begin
        for (int i = 1; i <= 64; i++) begin
            ip_next[i] = in_block[IP_TAB[i]];
            fp_next[i] = preout[FP_TAB[i]];
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            stage0_valid <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            stage0_valid <= in_valid;
            out_valid    <= stage2_valid;
        end
    end

    always_ff @(posedge ck) begin
        if (in_valid) begin
            stage0_block <= ip_next;
        end
        if (stage2_valid) begin
            out_block <= fp_next;
        end
    end

    des_round_chain #(
        .FIRST_ROUND (0),
        .ROUNDS      (HALF_ROUNDS)
    ) u_chain_lo (
        .ck        (ck),
        .rst_n     (rst_n),
        .in_valid  (stage0_valid),
        .in_block  (stage0_block),
        .subkeys   (subkeys),
        .out_valid (stage1_valid),
        .out_block (stage1_block)
    );

    des_round_chain #(
        .FIRST_ROUND (HALF_ROUNDS),
        .ROUNDS      (NUM_ROUNDS - HALF_ROUNDS)
    ) u_chain_hi (
        .ck        (ck),
        .rst_n     (rst_n),
        .in_valid  (stage1_valid),
        .in_block  (stage1_block),
        .subkeys   (subkeys),
        .out_valid (stage2_valid),
        .out_block (stage2_block)
    );

    // round 16 leaves L and R swapped, so R16 L16 feeds the final permutation.
    assign preout = {stage2_block[33:64], stage2_block[1:32]};

endmodule

// ==== dv/des_core_tb.sv ====
module des_core_tb
    import des_pkg::*;
();

    logic   ck;
    logic   rst_n;
    logic   key_load;
    block_t key;
    logic   decrypt;
    logic   in_valid;
    block_t in_block;
    logic   out_valid;
    block_t out_block;

    // cases as read from the data file.
    block_t case_key [$];
    logic   case_dec [$];
    block_t case_in [$];
    block_t case_exp [$];

    // blocks in flight and the cycle each must come out.
    block_t exp_block [$];
    int     exp_due [$];

    int          cycle_count = 0;
    int          timeout_limit = 20;
    logic [31:0] rng_state = 32'd5;

    des_core uut (
        .ck        (ck),
        .rst_n     (rst_n),
        .key_load  (key_load),
        .key       (key),
        .decrypt   (decrypt),
        .in_valid  (in_valid),
        .in_block  (in_block),
        .out_valid (out_valid),
        .out_block (out_block)
    );

    initial begin
        ck = 1'b0;
        forever #2 ck = ~ck;
    end

    function automatic logic [31:0] xorshift_next(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_block(input string what, input block_t actual, input block_t expected);
        if (actual !== expected) begin
            $display("FAIL %0t: %s got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "output block mismatch");
        end
    endtask

    task automatic check_valid(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL %0t: %s got %b, expected %b", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "out_valid mismatch");
        end
    endtask

    task automatic read_cases();
        int    fd;
        int    n;
        string line;
        block_t k;
        int    m;
        block_t b;
        block_t e;
        fd = $fopen("dv/des_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file dv/des_cases.txt");
            $display("TEST FAILED");
            $fatal(1, "missing case file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h", k, m, b, e);
                if (n != 4) begin
                    $display("malformed line in the case file: %s", line);
                    $display("TEST FAILED");
                    $fatal(1, "bad case line");
                end
                case_key.push_back(k);
                case_dec.push_back(m != 0);
                case_in.push_back(b);
                case_exp.push_back(e);
            end
        end
        $fclose(fd);
        if (case_key.size() == 0) begin
            $display("the case file holds no cases");
            $display("TEST FAILED");
            $fatal(1, "empty case file");
        end
        timeout_limit = 20 + 8 * case_key.size();
    endtask

    task automatic load_key(input block_t k, input logic dec);
        @(posedge ck);
        key_load <= 1'b1;
        key      <= k;
        decrypt  <= dec;
        in_valid <= 1'b0;
    endtask

    task automatic send_block(input block_t b, input block_t expected);
        @(posedge ck);
        key_load <= 1'b0;
        in_valid <= 1'b1;
        in_block <= b;
        exp_block.push_back(expected);
        exp_due.push_back(cycle_count + 5); // four cycles after the one with in_valid.
    endtask

    task automatic idle_cycle();
        @(posedge ck);
        key_load <= 1'b0;
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_block.size() != 0) begin
            @(posedge ck);
        end
        idle_cycle(); // out_valid must be low before the next key_load.
    endtask

    // outputs are settled at the falling edge.
    always @(negedge ck) begin
        logic want;
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("timeout: outputs missing");
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
        if (rst_n) begin
            want = (exp_due.size() != 0) && (exp_due[0] == cycle_count);
            check_valid("out_valid", out_valid, want);
            if (want) begin
                check_block("out_block", out_block, exp_block[0]);
                void'(exp_block.pop_front());
                void'(exp_due.pop_front());
            end
        end
    end

    initial begin
        int idx;
        int last;
        int grp;
        int gap;
        rst_n    = 1'b0;
        key_load = 1'b0;
        key      = '0;
        decrypt  = 1'b0;
        in_valid = 1'b0;
        in_block = '0;
        read_cases();
        repeat (5) @(posedge ck);
        rst_n <= 1'b1;
        repeat (3) idle_cycle();
        idx = 0;
        grp = 0;
        while (idx < case_key.size()) begin
            load_key(case_key[idx], case_dec[idx]);
            last = idx;
            while (last + 1 < case_key.size() && case_key[last+1] == case_key[idx]
                   && case_dec[last+1] == case_dec[idx]) begin
                last = last + 1;
            end
            // even groups stream back to back, odd groups get idle cycles.
            for (int i = idx; i <= last; i++) begin
                send_block(case_in[i], case_exp[i]);
                if (grp % 2 == 1) begin
                    rng_state = xorshift_next(rng_state);
                    gap = 1 + (rng_state % 2);
                    repeat (gap) idle_cycle();
                end
            end
            drain();
            idx = last + 1;
            grp = grp + 1;
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== dv/des_cases.txt ====
# key  mode  input  expected  (all hex)
# mode 0 encrypts and mode 1 decrypts
0123456789ABCDEF 0 4E6F772069732074 3FA40E8A984D4815
0123456789ABCDEF 0 68652074696D6520 6A271787AB8883F9
0123456789ABCDEF 0 666F7220616C6C20 893D51EC4B563B53
0123456789ABCDEF 0 1111111111111111 17668DFC7292532D
0123456789ABCDEF 1 3FA40E8A984D4815 4E6F772069732074
0123456789ABCDEF 1 6A271787AB8883F9 68652074696D6520
0123456789ABCDEF 1 893D51EC4B563B53 666F7220616C6C20
0123456789ABCDEF 1 17668DFC7292532D 1111111111111111
0101010101010101 0 8000000000000000 95F8A5E5DD31D900
0101010101010101 0 4000000000000000 DD7F121CA5015619
0101010101010101 0 2000000000000000 2E8653104F3834EA
0101010101010101 1 95F8A5E5DD31D900 8000000000000000
0101010101010101 1 DD7F121CA5015619 4000000000000000
0101010101010101 1 2E8653104F3834EA 2000000000000000
133457799BBCDFF1 0 0123456789ABCDEF 85E813540F0AB405
133457799BBCDFF1 1 85E813540F0AB405 0123456789ABCDEF
1111111111111111 0 1111111111111111 F40379AB9E0EC533
1111111111111111 0 0123456789ABCDEF 8A5AE1F81AB8F2DD
1111111111111111 1 F40379AB9E0EC533 1111111111111111
1111111111111111 1 8A5AE1F81AB8F2DD 0123456789ABCDEF
0E329232EA6D0D73 0 8787878787878787 0000000000000000
0E329232EA6D0D73 1 0000000000000000 8787878787878787
0000000000000000 0 0000000000000000 8CA64DE9C1B123A7
FFFFFFFFFFFFFFFF 0 FFFFFFFFFFFFFFFF 7359B2163E4EDC58
FFFFFFFFFFFFFFFF 1 7359B2163E4EDC58 FFFFFFFFFFFFFFFF
3000000000000000 0 1000000000000001 958E6E627A05557B
8001010101010101 0 0000000000000000 95A8D72813DAA94D
FEDCBA9876543210 0 0123456789ABCDEF ED39D950FA74BCC4
FEDCBA9876543210 1 ED39D950FA74BCC4 0123456789ABCDEF
7CA110454A1A6E57 0 01A1D6D039776742 690F5B0D9A26939B

// ==== des_core.f ====
verilog/des_pkg.sv
verilog/des_round.sv
verilog/des_round_chain.sv
verilog/des_key_schedule.sv
verilog/des_core.sv
dv/des_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the DES core testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module des_core_tb \
    -f des_core.f \
    -o des_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

if [ ! -x obj_dir/des_core_sim ]; then
    echo "simulation binary obj_dir/des_core_sim is missing"
    exit 1
fi

./obj_dir/des_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished"
exit 0
